// File: data_mem_subsys.f
+incdir+.
mem_subsys_pkg.sv
region_decoder.sv
region_ram.sv
response_combiner.sv
data_mem_subsys.sv
tb_data_mem_subsys.sv

// File: Makefile
# Verilator build and run for the data memory subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_data_mem_subsys
FILELIST  := data_mem_subsys.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"

# Fails unless the run prints the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_data_mem_subsys_table.svh
/* Directed test table */

// Columns: name, we, be, addr, wdata, idle cycles after, expected err, expected rdata
// Expected rdata is nonzero only on a read ack
task automatic load_table();
    // Region 0 fill at both ends, then read back
    add_vec("r0_wr_base",  1'b1, 4'hF, 32'h8000_0000, 32'h1122_3344, 4'd0, 1'b0, 32'h0);
    add_vec("r0_wr_last",  1'b1, 4'hF, 32'h8000_0FFC, 32'hA5A5_5A5A, 4'd0, 1'b0, 32'h0);
    add_vec("r0_rd_base",  1'b0, 4'hF, 32'h8000_0000, 32'h0,         4'd0, 1'b0, 32'h1122_3344);
    add_vec("r0_rd_last",  1'b0, 4'hF, 32'h8000_0FFC, 32'h0,         4'd2, 1'b0, 32'hA5A5_5A5A);
    // Region 1 at base and last word, region 0 must keep its data
    add_vec("r1_wr_base",  1'b1, 4'hF, 32'h8000_1000, 32'hCAFE_F00D, 4'd0, 1'b0, 32'h0);
    add_vec("r1_wr_last",  1'b1, 4'hF, 32'h8000_4FFC, 32'h0BAD_BEEF, 4'd0, 1'b0, 32'h0);
    add_vec("r0_rd_again", 1'b0, 4'hF, 32'h8000_0000, 32'h0,         4'd0, 1'b0, 32'h1122_3344);
    add_vec("r1_rd_base",  1'b0, 4'hF, 32'h8000_1000, 32'h0,         4'd0, 1'b0, 32'hCAFE_F00D);
    add_vec("r1_rd_last",  1'b0, 4'hF, 32'h8000_4FFC, 32'h0,         4'd2, 1'b0, 32'h0BAD_BEEF);
    // Partial byte enables, other lanes keep the old bytes
    add_vec("r0_wr_be5",   1'b1, 4'h5, 32'h8000_0000, 32'hFFEE_DDCC, 4'd0, 1'b0, 32'h0);
    add_vec("r0_rd_be5",   1'b0, 4'hF, 32'h8000_0000, 32'h0,         4'd0, 1'b0, 32'h11EE_33CC);
    add_vec("r1_wr_be8",   1'b1, 4'h8, 32'h8000_4FFC, 32'h7700_0000, 4'd0, 1'b0, 32'h0);
    add_vec("r1_rd_be8",   1'b0, 4'hF, 32'h8000_4FFC, 32'h0,         4'd2, 1'b0, 32'h77AD_BEEF);
    // Unmapped, below region 0 and past the end of region 1
    add_vec("low_rd",      1'b0, 4'hF, 32'h7FFF_FFFC, 32'h0,         4'd0, 1'b1, 32'h0);
    add_vec("low_wr",      1'b1, 4'hF, 32'h7FFF_FFFC, 32'hDEAD_0000, 4'd0, 1'b1, 32'h0);
    add_vec("high_rd",     1'b0, 4'hF, 32'h8000_5000, 32'h0,         4'd0, 1'b1, 32'h0);
    add_vec("zero_rd",     1'b0, 4'hF, 32'h0000_0000, 32'h0,         4'd2, 1'b1, 32'h0);
    // Back to back, alternating regions and misses
    add_vec("alt_r0",      1'b0, 4'hF, 32'h8000_0FFC, 32'h0,         4'd0, 1'b0, 32'hA5A5_5A5A);
    add_vec("alt_miss_rd", 1'b0, 4'hF, 32'hFFFF_FFFC, 32'h0,         4'd0, 1'b1, 32'h0);
    add_vec("alt_miss_wr", 1'b1, 4'hF, 32'h8000_5000, 32'h1234_5678, 4'd0, 1'b1, 32'h0);
    add_vec("alt_r1",      1'b0, 4'hF, 32'h8000_1000, 32'h0,         4'd0, 1'b0, 32'hCAFE_F00D);
    add_vec("alt_r0_base", 1'b0, 4'hF, 32'h8000_0000, 32'h0,         4'd2, 1'b0, 32'h11EE_33CC);
endtask

// File: tb_data_mem_subsys.sv
/* Data memory subsystem testbench */

`timescale 1ns/1ps

module tb_data_mem_subsys;
    import mem_subsys_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_COUNT   = 200;
    localparam int SEED         = 8;

    // One directed entry, name kept in a parallel queue
    typedef struct packed {
        logic       we;
        be_t        be;
        addr_t      addr;
        data_t      wdata;
        logic [3:0] gap;                 // Idle cycles after this entry
        logic       exp_err;
        data_t      exp_rdata;
    } vec_t;

    logic     clk;
    logic     rst_n;
    mem_req_t req;
    mem_rsp_t rsp;

    vec_t  table_q [$];
    string names [$];
    data_t shadow [addr_t];              // Word address to expected contents
    int    table_cycles = 0;
    bit    table_ready  = 1'b0;
    int    checks = 0;
    int    errors = 0;

    // Request in flight, answered at the next sample point
    logic  pend_valid = 1'b0;
    string pend_name;
    logic  pend_err;
    data_t pend_rdata;

    data_mem_subsys i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (req),
        .rsp_o (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Helpers
    // ==============================

    task automatic add_vec(input string name, input logic we, input be_t be, input addr_t addr,
                           input data_t wdata, input logic [3:0] gap, input logic exp_err,
                           input data_t exp_rdata);
        vec_t v;
        v = '{we: we, be: be, addr: addr, wdata: wdata, gap: gap, exp_err: exp_err,
              exp_rdata: exp_rdata};
        table_q.push_back(v);
        names.push_back(name);
    endtask

    `include "tb_data_mem_subsys_table.svh"

    // Byte lanes with be set take the new data
    function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t be);
        data_t res;
        res = old_w;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic in_window(addr_t a, addr_t base, int unsigned words);
        return (a >= base) && ((a - base) < addr_t'(words * BYTES_PER_WORD));
    endfunction

    function automatic logic is_mapped(addr_t a);
        return in_window(a, REGION0_BASE, REGION0_WORDS) ||
               in_window(a, REGION1_BASE, REGION1_WORDS);
    endfunction

    // Words near both ends of each region, now and then an unmapped one
    function automatic addr_t pick_addr();
        int unsigned kind;
        int unsigned idx;
        kind = $urandom % 16;
        idx  = $urandom % 8;
        if (kind < 7) begin
            if (kind % 2 == 0) idx = REGION0_WORDS - 1 - idx;   // Top end
            return REGION0_BASE + addr_t'(idx * BYTES_PER_WORD);
        end else if (kind < 14) begin
            if (kind % 2 == 0) idx = REGION1_WORDS - 1 - idx;
            return REGION1_BASE + addr_t'(idx * BYTES_PER_WORD);
        end else if (kind == 14) begin
            return REGION0_BASE - addr_t'((idx + 1) * BYTES_PER_WORD);  // Just below
        end
        return REGION1_BASE + addr_t'((REGION1_WORDS + idx) * BYTES_PER_WORD); // Past end
    endfunction

    task automatic update_shadow(input mem_req_t r);
        if (r.we && is_mapped(r.addr)) begin
            if (shadow.exists(r.addr)) begin
                shadow[r.addr] = merge_bytes(shadow[r.addr], r.wdata, r.be);
            end else if (r.be == '1) begin
                shadow[r.addr] = r.wdata;                       // Word now fully known
            end
        end
    endtask

    task automatic check_rsp(input string name, input logic exp_ack, input logic exp_err,
                             input data_t exp_rdata);
        checks++;
        assert (rsp.ack === exp_ack) else begin
            $display("ERROR %s ack: expected %0b, actual %0b", name, exp_ack, rsp.ack);
            errors++;
        end
        assert (rsp.err === exp_err) else begin
            $display("ERROR %s err: expected %0b, actual %0b", name, exp_err, rsp.err);
            errors++;
        end
        assert (rsp.rdata === exp_rdata) else begin
            $display("ERROR %s rdata: expected %h, actual %h", name, exp_rdata, rsp.rdata);
            errors++;
        end
    endtask

    // Drive one cycle, then check the answer to the previous cycle
    task automatic issue_cycle(input mem_req_t r, input string name, input logic exp_err,
                               input data_t exp_rdata);
        @(posedge clk);
        req <= r;
        @(negedge clk);                  // Outputs settled mid cycle
        if (pend_valid) begin
            check_rsp(pend_name, !pend_err, pend_err, pend_rdata);
        end else begin
            check_rsp("idle", 1'b0, 1'b0, '0);                  // No stray pulse
        end
        pend_valid = r.valid;
        pend_name  = name;
        pend_err   = exp_err;
        pend_rdata = exp_rdata;
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        vec_t     v;
        mem_req_t r;
        logic     mapped;
        data_t    exp_rdata;
        void'($urandom(SEED));
        clk   = 1'b0;
        rst_n = 1'b1;                    // Reset active while high
        req   = '0;
        load_table();
        foreach (table_q[i]) table_cycles += 1 + int'(table_q[i].gap);
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) issue_cycle('0, "idle", 1'b0, '0);          // Quiet after reset

        foreach (table_q[i]) begin
            v = table_q[i];
            r = '{valid: 1'b1, we: v.we, be: v.be, addr: v.addr, wdata: v.wdata};
            issue_cycle(r, names[i], v.exp_err, v.exp_rdata);
            update_shadow(r);
            repeat (int'(v.gap)) issue_cycle('0, "idle", 1'b0, '0);
        end

        // Back-to-back random accesses against the shadow model
        for (int n = 0; n < RAND_COUNT; n++) begin
            r       = '0;
            r.valid = 1'b1;
            r.addr  = pick_addr();
            r.we    = ($urandom % 2) == 1;
            r.be    = be_t'($urandom);
            r.wdata = $urandom;
            mapped  = is_mapped(r.addr);
            if (mapped && !shadow.exists(r.addr)) begin
                r.we = 1'b1;             // First touch writes the whole word
                r.be = '1;
            end
            exp_rdata = (mapped && !r.we) ? shadow[r.addr] : '0;
            issue_cycle(r, $sformatf("rand_%0d", n), !mapped, exp_rdata);
            update_shadow(r);
        end
        repeat (2) issue_cycle('0, "idle", 1'b0, '0);          // Drain the last answer

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the test length
    initial begin
        wait (table_ready);
        #((table_cycles + RAND_COUNT + 20) * CLK_PERIOD);
        $display("Timeout: the test did not finish in %0d cycles",
                 table_cycles + RAND_COUNT + 20);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: data_mem_subsys.sv
/* Data memory subsystem top */

`timescale 1ns/1ps

module data_mem_subsys (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_subsys_pkg::mem_req_t req_i,
    output mem_subsys_pkg::mem_rsp_t rsp_o
);
    import mem_subsys_pkg::*;

    logic     sel0;                     // Region strobes from decoder
    logic     sel1;
    logic     miss;
    mem_rsp_t ram0_rsp;
    mem_rsp_t ram1_rsp;

    // ==============================
    // Address decode
    // ==============================

    region_decoder u_decoder (
        .req_i  (req_i),
        .sel0_o (sel0),
        .sel1_o (sel1),
        .miss_o (miss)
    );

    // ==============================
    // Region memories
    // ==============================

    region_ram #(
        .WORDS (REGION0_WORDS)          // 4 KB at REGION0_BASE
    ) u_region0 (
        .clk   (clk),
        .rst_n (rst_n),
        .sel_i (sel0),
        .req_i (req_i),
        .rsp_o (ram0_rsp)
    );

    region_ram #(
        .WORDS (REGION1_WORDS)          // 16 KB at REGION1_BASE
    ) u_region1 (
        .clk   (clk),
        .rst_n (rst_n),
        .sel_i (sel1),
        .req_i (req_i),
        .rsp_o (ram1_rsp)
    );

    // Answer path, one cycle after the strobe
    response_combiner u_combiner (
        .clk        (clk),
        .rst_n      (rst_n),
        .ram0_rsp_i (ram0_rsp),
        .ram1_rsp_i (ram1_rsp),
        .miss_i     (miss),
        .rsp_o      (rsp_o)
    );

endmodule

// File: response_combiner.sv
/* Region response combiner */

`timescale 1ns/1ps

module response_combiner (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_subsys_pkg::mem_rsp_t ram0_rsp_i,
    input  mem_subsys_pkg::mem_rsp_t ram1_rsp_i,
    input  logic                     miss_i,
    output mem_subsys_pkg::mem_rsp_t rsp_o
);
    import mem_subsys_pkg::*;

    logic  miss_q;                      // Miss delayed to line up with memory acks
    data_t rdata;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            miss_q <= 1'b0;
        end else begin
            miss_q <= miss_i;
        end
    end

    // ==============================
    // Response merge
    // ==============================

    // Pick data from the memory that answered
    always_comb begin
        rdata = '0;
        if (ram0_rsp_i.ack) begin
            rdata = ram0_rsp_i.rdata;
        end else if (ram1_rsp_i.ack) begin
            rdata = ram1_rsp_i.rdata;
        end
    end

    assign rsp_o.ack   = ram0_rsp_i.ack | ram1_rsp_i.ack;
    assign rsp_o.err   = miss_q | ram0_rsp_i.err | ram1_rsp_i.err;
    assign rsp_o.rdata = rdata;

    // Decoder selects only one region per request
    a_single_ram_ack : assert property (@(posedge clk) disable iff (rst_n)
        !(ram0_rsp_i.ack && ram1_rsp_i.ack))
        else $error("response_combiner: both region memories acked");

    // A request ends in ack or err, never both
    a_ack_err_excl : assert property (@(posedge clk) disable iff (rst_n)
        !(rsp_o.ack && rsp_o.err))
        else $error("response_combiner: ack and err in the same cycle");

endmodule

// File: region_ram.sv
/* Byte-enable region memory */

`timescale 1ns/1ps

module region_ram #(
    parameter int unsigned WORDS = mem_subsys_pkg::REGION0_WORDS
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sel_i,
    input  mem_subsys_pkg::mem_req_t req_i,
    output mem_subsys_pkg::mem_rsp_t rsp_o
);
    import mem_subsys_pkg::*;

    localparam int unsigned IDX_W = $clog2(WORDS);          // Word index width
    localparam int unsigned OFS_W = $clog2(BYTES_PER_WORD); // Byte offset width

    // ==============================
    // Storage
    // ==============================

    data_t mem [WORDS];                 // Contents survive reset

    logic [IDX_W-1:0] idx;
    logic             ack_q;
    data_t            rdata_q;

    // Region offset is implied by dropping the upper address bits
    assign idx = req_i.addr[OFS_W +: IDX_W];

    // Write the enabled lanes only
    always_ff @(posedge clk) begin
        if (sel_i && req_i.we) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (req_i.be[b]) begin
                    mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Read data, old word on a same-cycle hazard
    always_ff @(posedge clk) begin
        if (sel_i) begin
            rdata_q <= req_i.we ? '0 : mem[idx]; // Zero on write ack
        end
    end

    // ==============================
    // Acknowledge
    // ==============================

    always_ff @(posedge clk) begin
        if (rst_n) begin                // Reset is active high
            ack_q <= 1'b0;
        end else begin
            ack_q <= sel_i;             // Fixed one cycle latency
        end
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.err   = 1'b0;          // Range already checked by decoder
    assign rsp_o.rdata = rdata_q;

    // Every ack pulse traces back to a select carried by a valid request
    a_ack_after_sel : assert property (@(posedge clk) disable iff (rst_n)
        rsp_o.ack |-> $past(sel_i && req_i.valid))
        else $error("region_ram: ack without a valid select in the previous cycle");

endmodule

// File: region_decoder.sv
/* Region address decoder */

`timescale 1ns/1ps

module region_decoder (
    input  mem_subsys_pkg::mem_req_t req_i,
    output logic                     sel0_o,
    output logic                     sel1_o,
    output logic                     miss_o
);
    import mem_subsys_pkg::*;

    // Window sizes in bytes
    localparam addr_t REGION0_SPAN = addr_t'(REGION0_WORDS * BYTES_PER_WORD);
    localparam addr_t REGION1_SPAN = addr_t'(REGION1_WORDS * BYTES_PER_WORD);

    addr_t off0; // Offset from region 0 base, wraps when below it
    addr_t off1;
    logic  hit0;
    logic  hit1;

    // Unsigned offset compare covers both ends of each window
    assign off0 = req_i.addr - REGION0_BASE;
    assign off1 = req_i.addr - REGION1_BASE;
    assign hit0 = (off0 < REGION0_SPAN);
    assign hit1 = (off1 < REGION1_SPAN);

    // One strobe per window, decoded independently
    assign sel0_o = req_i.valid & hit0;
    assign sel1_o = req_i.valid & hit1;
    assign miss_o = req_i.valid & ~hit0 & ~hit1;    // Outside both windows

    // Overlapping windows would raise two strobes
    a_sel_onehot : assert property (@(req_i) $onehot0({sel0_o, sel1_o, miss_o}))
        else $error("region_decoder: more than one strobe raised");

endmodule

// File: mem_subsys_pkg.sv
/* Data memory subsystem definitions */

package mem_subsys_pkg;

    // ==============================
    // Memory map
    // ==============================

    localparam logic [31:0] REGION0_BASE = 32'h8000_0000; // Small region, 4 KB window
    localparam int unsigned REGION0_WORDS = 1024;

    localparam logic [31:0] REGION1_BASE = 32'h8000_1000; // Large region, 16 KB window
    localparam int unsigned REGION1_WORDS = 4096;

    localparam int unsigned BYTES_PER_WORD = 4;           // Byte to word address shift

    // ==============================
    // Bus types
    // ==============================

    typedef logic [31:0] addr_t;                          // Byte address
    typedef logic [31:0] data_t;                          // One data word
    typedef logic [BYTES_PER_WORD-1:0] be_t;              // One enable per byte lane

    // Request, valid is a single cycle strobe
    typedef struct packed {
        logic  valid;
        logic  we;                                        // 1 = write, 0 = read
        be_t   be;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // Response, exactly one of ack or err per accepted request
    typedef struct packed {
        logic  ack;
        logic  err;
        data_t rdata;                                     // Zero unless read ack
    } mem_rsp_t;

endpackage
